// ==== logic/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Issue slots on the way in, commit slots on the way out
`define ISSUE_WIDTH 2

// Threads per warp and physical ALU lanes
`define NUM_THREADS 4
`define NUM_LANES   2

`define NUM_WARPS   4

`define XLEN        32
`define UUID_WIDTH  8

// Register index width (32 architectural registers)
`define NR_BITS     5

// Derived widths
`define NW_WIDTH    ($clog2(`NUM_WARPS))

// Number of lane packets one instruction is split into
`define NUM_PKTS    (`NUM_THREADS / `NUM_LANES)

// Packet index width, one bit with four threads on two lanes
`define PID_WIDTH   ($clog2(`NUM_PKTS))

`endif

// ==== logic/exec_pkg.sv ====
`default_nettype none
`include "exec_config.svh"

package exec_pkg;

    // ALU opcodes, SLT compares as signed and returns 1 or 0
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5
    } alu_op_e;

    // Full warp instruction as presented by an issue slot
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]                uuid;
        logic [`NW_WIDTH-1:0]                  wid;
        logic [`NUM_THREADS-1:0]               tmask;
        logic [`XLEN-1:0]                      pc;
        alu_op_e                               op;
        logic [`NR_BITS-1:0]                   rd;
        logic                                  wb;
        logic [`NUM_THREADS-1:0][`XLEN-1:0]    rs1;
        logic [`NUM_THREADS-1:0][`XLEN-1:0]    rs2;
    } issue_t;

    // One lane-wide slice of an instruction
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]                uuid;
        logic [`NW_WIDTH-1:0]                  wid;
        logic [`NUM_LANES-1:0]                 tmask;
        logic [`XLEN-1:0]                      pc;
        alu_op_e                               op;
        logic [`NR_BITS-1:0]                   rd;
        logic                                  wb;
        logic [`NUM_LANES-1:0][`XLEN-1:0]      rs1;
        logic [`NUM_LANES-1:0][`XLEN-1:0]      rs2;
        logic [`PID_WIDTH-1:0]                 pid;
        logic                                  sop;
        logic                                  eop;
    } packet_t;

    // ALU result for one lane packet
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]                uuid;
        logic [`NW_WIDTH-1:0]                  wid;
        logic [`NUM_LANES-1:0]                 tmask;
        logic [`XLEN-1:0]                      pc;
        logic                                  wb;
        logic [`NR_BITS-1:0]                   rd;
        logic [`NUM_LANES-1:0][`XLEN-1:0]      data;
        logic [`PID_WIDTH-1:0]                 pid;
        logic                                  sop;
        logic                                  eop;
    } lane_commit_t;

    // Commit widened back to thread width, pid is always zero here
    typedef struct packed {
        logic [`UUID_WIDTH-1:0]                uuid;
        logic [`NW_WIDTH-1:0]                  wid;
        logic [`NUM_THREADS-1:0]               tmask;
        logic [`XLEN-1:0]                      pc;
        logic                                  wb;
        logic [`NR_BITS-1:0]                   rd;
        logic [`NUM_THREADS-1:0][`XLEN-1:0]    data;
        logic [`PID_WIDTH-1:0]                 pid;
        logic                                  sop;
        logic                                  eop;
    } commit_t;

endpackage

`default_nettype wire

// ==== logic/elastic_buffer.sv ====
`default_nettype none

module elastic_buffer #(
    parameter int DATAW = 32
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              valid_in,
    input  wire  [DATAW-1:0] data_in,
    output logic             ready_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  wire              ready_out
);
    logic             out_valid_r;
    logic [DATAW-1:0] out_data_r;
    logic             skid_valid_r;
    logic [DATAW-1:0] skid_data_r;
    logic             out_load;
    logic             in_fire;

    // Output register is free when empty or drained this cycle
    assign out_load = !out_valid_r || ready_out;

    // Only the skid slot decides ready, so there is no path from ready_out
    assign ready_in = !skid_valid_r;
    assign in_fire  = valid_in && ready_in;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_r  <= 1'b0;
            skid_valid_r <= 1'b0;
        end else begin
            if (out_load) begin
                out_valid_r <= skid_valid_r || in_fire;
            end
            // The skid entry fills when a word arrives behind a stalled output
            if (out_load) begin
                skid_valid_r <= 1'b0;
            end else if (in_fire) begin
                skid_valid_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data_r <= skid_valid_r ? skid_data_r : data_in;
        end
        if (in_fire && !out_load) begin
            skid_data_r <= data_in;
        end
    end

    assign valid_out = out_valid_r;
    assign data_out  = out_data_r;

    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        (valid_out && !ready_out) |=> (valid_out && $stable(data_out))
    ) else $error("elastic_buffer: output changed while stalled");

endmodule

`default_nettype wire

// ==== logic/lane_dispatcher.sv ====
`default_nettype none
`include "exec_config.svh"

module lane_dispatcher (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire  [`ISSUE_WIDTH-1:0]                  issue_valid,
    input  wire  exec_pkg::issue_t [`ISSUE_WIDTH-1:0] issue_data,
    output logic [`ISSUE_WIDTH-1:0]                  issue_ready,
    output logic                                     pkt_valid,
    output exec_pkg::packet_t                        pkt,
    input  wire                                      pkt_ready
);
    import exec_pkg::*;

    localparam int SLOT_W = (`ISSUE_WIDTH > 1) ? $clog2(`ISSUE_WIDTH) : 1;
    localparam int PID_W  = `PID_WIDTH;
    localparam logic [PID_W-1:0] LAST_PID = PID_W'(`NUM_PKTS - 1);

    logic [SLOT_W-1:0] rr_ptr;
    logic [SLOT_W-1:0] lock_slot;
    logic [PID_W-1:0]  pid_r;
    logic              locked;
    logic [SLOT_W-1:0] pick_slot;
    logic              pick_found;
    logic [SLOT_W-1:0] sel_slot;
    logic              is_eop;
    logic              pkt_fire;
    issue_t            sel_issue;

    function automatic logic [SLOT_W-1:0] next_slot(input logic [SLOT_W-1:0] slot);
        if (slot == SLOT_W'(`ISSUE_WIDTH - 1)) begin
            return '0;
        end
        return slot + 1'b1;
    endfunction

    // A slot stays locked while any of its packets is still outstanding
    assign locked = (pid_r != '0);

    // Round-robin search starting at the pointer
    always_comb begin
        logic [SLOT_W-1:0] idx;
        idx        = rr_ptr;
        pick_slot  = rr_ptr;
        pick_found = 1'b0;
        for (int k = 0; k < `ISSUE_WIDTH; k++) begin
            if (!pick_found && issue_valid[idx]) begin
                pick_slot  = idx;
                pick_found = 1'b1;
            end
            idx = next_slot(idx);
        end
    end

    assign sel_slot  = locked ? lock_slot : pick_slot;
    assign sel_issue = issue_data[sel_slot];
    assign pkt_valid = locked ? issue_valid[lock_slot] : pick_found;
    assign is_eop    = (pid_r == LAST_PID);
    assign pkt_fire  = pkt_valid && pkt_ready;

    // The instruction is only consumed with its last packet
    always_comb begin
        issue_ready = '0;
        issue_ready[sel_slot] = pkt_fire && is_eop;
    end

    // Slice the thread mask and operands by packet index
    always_comb begin
        pkt.uuid = sel_issue.uuid;
        pkt.wid  = sel_issue.wid;
        pkt.pc   = sel_issue.pc;
        pkt.op   = sel_issue.op;
        pkt.rd   = sel_issue.rd;
        pkt.wb   = sel_issue.wb;
        for (int j = 0; j < `NUM_LANES; j++) begin
            pkt.tmask[j] = sel_issue.tmask[int'(pid_r) * `NUM_LANES + j];
            pkt.rs1[j]   = sel_issue.rs1[int'(pid_r) * `NUM_LANES + j];
            pkt.rs2[j]   = sel_issue.rs2[int'(pid_r) * `NUM_LANES + j];
        end
        pkt.pid = pid_r;
        pkt.sop = (pid_r == '0);
        pkt.eop = is_eop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr    <= '0;
            lock_slot <= '0;
            pid_r     <= '0;
        end else if (pkt_fire) begin
            if (is_eop) begin
                pid_r  <= '0;
                // next grant prefers the slot after the one just served
                rr_ptr <= next_slot(sel_slot);
            end else begin
                pid_r     <= pid_r + 1'b1;
                lock_slot <= sel_slot;
            end
        end
    end

    // Commit routing relies on the warp id matching the issue slot
    for (genvar g = 0; g < `ISSUE_WIDTH; g++) begin : g_wid_chk
        a_wid_slot: assert property (
            @(posedge clk) disable iff (rst)
            issue_valid[g] |-> ((int'(issue_data[g].wid) % `ISSUE_WIDTH) == g)
        ) else $error("lane_dispatcher: wid does not map to slot %0d", g);
    end

    a_lock_hold: assert property (
        @(posedge clk) disable iff (rst)
        locked |-> issue_valid[lock_slot]
    ) else $error("lane_dispatcher: locked slot dropped valid");

endmodule

`default_nettype wire

// ==== logic/lane_alu.sv ====
`default_nettype none
`include "exec_config.svh"

module lane_alu (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    pkt_valid,
    input  wire exec_pkg::packet_t pkt,
    output logic                   pkt_ready,
    output logic                   out_valid,
    output exec_pkg::lane_commit_t out,
    input  wire                    out_ready
);
    import exec_pkg::*;

    logic [`NUM_LANES-1:0][`XLEN-1:0] result;
    logic                             pkt_fire;

    function automatic logic [`XLEN-1:0] alu_eval(
        input alu_op_e          op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        logic lt;
        lt = ($signed(a) < $signed(b));
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return {{(`XLEN-1){1'b0}}, lt};
            default: return '0;
        endcase
    endfunction

    // Stage accepts when its register is empty or emptying
    assign pkt_ready = !out_valid || out_ready;
    assign pkt_fire  = pkt_valid && pkt_ready;

    // Every lane is evaluated, the mask only marks which results count
    always_comb begin
        for (int j = 0; j < `NUM_LANES; j++) begin
            result[j] = alu_eval(pkt.op, pkt.rs1[j], pkt.rs2[j]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (pkt_ready) begin
            out_valid <= pkt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_fire) begin
            out.uuid  <= pkt.uuid;
            out.wid   <= pkt.wid;
            out.tmask <= pkt.tmask;
            out.pc    <= pkt.pc;
            out.wb    <= pkt.wb;
            out.rd    <= pkt.rd;
            out.data  <= result;
            out.pid   <= pkt.pid;
            out.sop   <= pkt.sop;
            out.eop   <= pkt.eop;
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out))
    ) else $error("lane_alu: result changed while stalled");

endmodule

`default_nettype wire

// ==== logic/commit_gather.sv ====
`default_nettype none
`include "exec_config.svh"

module commit_gather #(
    parameter int BLOCK_SIZE = 1
) (
    input  wire                                          clk,
    input  wire                                          rst,
    input  wire  [BLOCK_SIZE-1:0]                        in_valid,
    input  wire  exec_pkg::lane_commit_t [BLOCK_SIZE-1:0] in_data,
    output logic [BLOCK_SIZE-1:0]                        in_ready,
    output logic [`ISSUE_WIDTH-1:0]                      commit_valid,
    output exec_pkg::commit_t [`ISSUE_WIDTH-1:0]         commit_data,
    input  wire  [`ISSUE_WIDTH-1:0]                      commit_ready
);
    import exec_pkg::*;

    localparam int SLOT_W = (`ISSUE_WIDTH > 1) ? $clog2(`ISSUE_WIDTH) : 1;
    localparam int LC_W   = $bits(lane_commit_t);

    logic [BLOCK_SIZE-1:0][SLOT_W-1:0] in_slot;
    logic [`ISSUE_WIDTH-1:0]           buf_valid;
    lane_commit_t [`ISSUE_WIDTH-1:0]   buf_data;
    logic [`ISSUE_WIDTH-1:0]           buf_ready;

    // Target slot per input block
    for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_slot_map
        if (BLOCK_SIZE == `ISSUE_WIDTH) begin : g_direct
            // One block per slot, the block index is the slot
            assign in_slot[i] = SLOT_W'(i);
        end else begin : g_by_wid
            assign in_slot[i] = in_data[i].wid[SLOT_W-1:0];
        end
        // Only the buffer this packet is headed for can stall it
        assign in_ready[i] = buf_ready[in_slot[i]];
    end

    always_comb begin
        buf_valid = '0;
        buf_data  = '0;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            buf_valid[in_slot[i]] = in_valid[i];
            buf_data[in_slot[i]]  = in_data[i];
        end
    end

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_slot
        lane_commit_t                     head;
        logic [`NUM_THREADS-1:0]          wide_tmask;
        logic [`NUM_THREADS-1:0][`XLEN-1:0] wide_data;
        commit_t                          wide;

        elastic_buffer #(
            .DATAW (LC_W)
        ) u_buf (
            .clk       (clk),
            .rst       (rst),
            .valid_in  (buf_valid[s]),
            .data_in   (buf_data[s]),
            .ready_in  (buf_ready[s]),
            .valid_out (commit_valid[s]),
            .data_out  (head),
            .ready_out (commit_ready[s])
        );

        // Lanes land at thread pid * NUM_LANES onward, all other threads stay clear
        always_comb begin
            wide_tmask = '0;
            wide_data  = '0;
            for (int j = 0; j < `NUM_LANES; j++) begin
                wide_tmask[int'(head.pid) * `NUM_LANES + j] = head.tmask[j];
                wide_data[int'(head.pid) * `NUM_LANES + j]  = head.data[j];
            end
        end

        always_comb begin
            wide.uuid  = head.uuid;
            wide.wid   = head.wid;
            wide.tmask = wide_tmask;
            wide.pc    = head.pc;
            wide.wb    = head.wb;
            wide.rd    = head.rd;
            wide.data  = wide_data;
            // The commit is already thread-wide.
            wide.pid   = '0;
            wide.sop   = head.sop;
            wide.eop   = head.eop;
        end

        assign commit_data[s] = wide;
    end

endmodule

`default_nettype wire

// ==== logic/exec_slice.sv ====
`default_nettype none
`include "exec_config.svh"

module exec_slice (
    input  wire                                       clk,
    input  wire                                       rst,
    input  wire  [`ISSUE_WIDTH-1:0]                   issue_valid,
    input  wire  exec_pkg::issue_t [`ISSUE_WIDTH-1:0] issue_data,
    output logic [`ISSUE_WIDTH-1:0]                   issue_ready,
    output logic [`ISSUE_WIDTH-1:0]                   commit_valid,
    output exec_pkg::commit_t [`ISSUE_WIDTH-1:0]      commit_data,
    input  wire  [`ISSUE_WIDTH-1:0]                   commit_ready
);
    import exec_pkg::*;

    // Dispatcher to ALU
    logic         pkt_valid;
    packet_t      pkt;
    logic         pkt_ready;

    // ALU to gather stage
    logic         lc_valid;
    lane_commit_t lane_commit;
    logic         lc_ready;

    lane_dispatcher u_dispatch (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_data  (issue_data),
        .issue_ready (issue_ready),
        .pkt_valid   (pkt_valid),
        .pkt         (pkt),
        .pkt_ready   (pkt_ready)
    );

    lane_alu u_alu (
        .clk       (clk),
        .rst       (rst),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .pkt_ready (pkt_ready),
        .out_valid (lc_valid),
        .out       (lane_commit),
        .out_ready (lc_ready)
    );

    // Single ALU block, so slots are told apart by warp id
    commit_gather #(
        .BLOCK_SIZE (1)
    ) u_gather (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (lc_valid),
        .in_data      (lane_commit),
        .in_ready     (lc_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

endmodule

`default_nettype wire

// ==== dv/exec_slice_tb.sv ====
`default_nettype none
`include "exec_config.svh"

module exec_slice_tb;
    import exec_pkg::*;

    localparam int NUM_INSTR  = 150;
    localparam int MAX_CYCLES = 6000;

    logic                                clk;
    logic                                rst;
    logic [`ISSUE_WIDTH-1:0]             issue_valid;
    issue_t [`ISSUE_WIDTH-1:0]           issue_data;
    logic [`ISSUE_WIDTH-1:0]             issue_ready;
    logic [`ISSUE_WIDTH-1:0]             commit_valid;
    commit_t [`ISSUE_WIDTH-1:0]          commit_data;
    logic [`ISSUE_WIDTH-1:0]             commit_ready;

    // Expected commits per slot with the head mirrored into plain variables
    commit_t                             exp_q [`ISSUE_WIDTH][$];
    commit_t                             exp_head [`ISSUE_WIDTH];
    logic [`ISSUE_WIDTH-1:0]             exp_empty;
    int                                  accepted [`ISSUE_WIDTH];
    int                                  errors;
    int                                  cycles;

    exec_slice dut (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .commit_ready (commit_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] ref_alu(input alu_op_e op, input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b);
        logic signed [`XLEN-1:0] sa;
        logic signed [`XLEN-1:0] sb;
        sa = a;
        sb = b;
        if (op == ADD) return a + b;
        if (op == SUB) return a - b;
        if (op == AND) return a & b;
        if (op == OR)  return a | b;
        if (op == XOR) return a ^ b;
        return (sa < sb) ? `XLEN'(1) : `XLEN'(0);
    endfunction

    // Expected commit for one half of the warp with the other threads left at zero
    function automatic commit_t expected_commit(input issue_t ins, input int half);
        commit_t c;
        int      t;
        c = '0;
        c.uuid = ins.uuid;
        c.wid  = ins.wid;
        c.pc   = ins.pc;
        c.wb   = ins.wb;
        c.rd   = ins.rd;
        c.sop  = (half == 0);
        c.eop  = (half == `NUM_PKTS - 1);
        for (int j = 0; j < `NUM_LANES; j++) begin
            t = half * `NUM_LANES + j;
            c.tmask[t] = ins.tmask[t];
            c.data[t]  = ref_alu(ins.op, ins.rs1[t], ins.rs2[t]);
        end
        return c;
    endfunction

    function automatic logic [`XLEN-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return 32'h0000_0001;
            default: return $urandom();
        endcase
    endfunction

    function automatic issue_t random_instr(input int slot, input int idx);
        issue_t ins;
        ins.uuid  = idx[`UUID_WIDTH-1:0];
        ins.wid   = `NW_WIDTH'(slot + `ISSUE_WIDTH * $urandom_range(0, 1));
        ins.tmask = ($urandom_range(0, 7) == 0) ? '0 : `NUM_THREADS'($urandom());
        ins.pc    = $urandom();
        ins.op    = alu_op_e'($urandom_range(0, 5));
        ins.rd    = `NR_BITS'($urandom());
        ins.wb    = 1'($urandom());
        for (int t = 0; t < `NUM_THREADS; t++) begin
            ins.rs1[t] = pick_operand();
            ins.rs2[t] = pick_operand();
        end
        return ins;
    endfunction

    task automatic drive_slot(input int slot);
        for (int i = 0; i < NUM_INSTR; i++) begin
            repeat ($urandom_range(0, 3)) @(negedge clk);
            issue_data[slot]  = random_instr(slot, i);
            issue_valid[slot] = 1'b1;
            do @(negedge clk); while (accepted[slot] == i);
            issue_valid[slot] = 1'b0;
        end
    endtask

    // The reference model updates on every handshake seen at the rising edge
    always @(posedge clk) begin
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            if (!rst && commit_valid[s] && commit_ready[s] && exp_q[s].size() > 0) begin
                void'(exp_q[s].pop_front());
            end
            if (!rst && issue_valid[s] && issue_ready[s]) begin
                for (int h = 0; h < `NUM_PKTS; h++) begin
                    exp_q[s].push_back(expected_commit(issue_data[s], h));
                end
                accepted[s]++;
            end
            exp_empty[s] = (exp_q[s].size() == 0);
            exp_head[s]  = exp_empty[s] ? commit_t'('0) : exp_q[s][0];
        end
        cycles++;
    end

    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_check
        a_commit_match: assert property (
            @(posedge clk) disable iff (rst)
            (commit_valid[s] && commit_ready[s])
                |-> (!exp_empty[s] && commit_data[s] == exp_head[s])
        ) else begin
            errors++;
            $display("error at %0t: slot %0d commit uuid %0d sop=%0b differs from model",
                     $time, s, commit_data[s].uuid, commit_data[s].sop);
        end

        a_slot_route: assert property (
            @(posedge clk) disable iff (rst)
            commit_valid[s] |-> (int'(commit_data[s].wid) % `ISSUE_WIDTH == s)
        ) else begin
            errors++;
            $display("error at %0t: wid %0d appeared on slot %0d", $time, commit_data[s].wid, s);
        end

        // An instruction is only taken with its last packet, which needs a valid slot
        a_ready_valid: assert property (
            @(posedge clk) disable iff (rst)
            issue_ready[s] |-> issue_valid[s]
        ) else begin
            errors++;
            $display("error at %0t: issue ready on slot %0d without a valid instruction",
                     $time, s);
        end
    end

    a_reset_quiet: assert property (
        @(posedge clk) (rst && cycles > 0) |=> (commit_valid == '0 && issue_ready == '0)
    ) else begin
        errors++;
        $display("error at %0t: commit valid or issue ready high during or right after reset",
                 $time);
    end

    // Random back-pressure plus one long stall on slot 1
    initial begin
        forever begin
            @(negedge clk);
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                commit_ready[s] = ($urandom_range(0, 9) >= 3);
            end
            if (cycles >= 400 && cycles < 440) begin
                commit_ready[1] = 1'b0;
            end
        end
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("Timeout: the run did not drain within %0d cycles", MAX_CYCLES);
        $display("Summary: %0d errors", errors);
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hc2b2));
        rst          = 1'b1;
        issue_valid  = '0;
        issue_data   = '0;
        commit_ready = '0;
        errors       = 0;
        cycles       = 0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            accepted[s] = 0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        fork
            drive_slot(0);
            drive_slot(1);
        join
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(negedge clk);
        end
        // A few idle cycles catch any repeated commit
        repeat (20) @(negedge clk);
        $display("Summary: %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/exec_pkg.sv
logic/elastic_buffer.sv
logic/lane_dispatcher.sv
logic/lane_alu.sv
logic/commit_gather.sv
logic/exec_slice.sv
dv/exec_slice_tb.sv
